/* include/pic_macros.svh */
// Width, command-bit and timing macros of the interrupt controller
`ifndef PIC_MACROS_SVH
`define PIC_MACROS_SVH

// Widths
`define PIC_LINES        8      // Request lines IR0..IR7
`define PIC_IDX_W        3      // Bits of a level index
`define PIC_DATA_W       8      // Processor data byte
`define PIC_BASE_W       5      // Vector base field of ICW2

// Command word bits
`define PIC_LTIM_BIT     3      // ICW1 level/edge select
`define PIC_ICW1_FLAG    4      // Marks ICW1 at address 0
`define PIC_OCW3_FLAG    3      // Tells OCW3 from OCW2
`define PIC_OCW3_RR_BIT  1      // OCW3 read-register enable
`define PIC_OCW3_RIS_BIT 0      // OCW3 ISR/IRR select
`define PIC_EOI_CODE     3'b001 // OCW2 bits 7:5 for non-specific EOI

// Cycle limits around the processor port
`define PIC_WAIT_LIMIT   20     // Longest wait for intr or vectorValid
`define PIC_QUIET_CYCLES 8      // Window in which intr must stay low
`define PIC_CYCLES_PER_CMD 40   // Cycle budget per command line

`endif

/* logic/inServiceRegister.sv */
// In-service register with acknowledge set and non-specific EOI clear
`timescale 1ns/1ps
`default_nettype none

module inServiceRegister (
    input  wire                  clk,
    input  wire                  resetIRR,
    input  wire                  setStrobe,   // First acknowledge pulse
    input  wire picPkg::levelIdx setIndex,
    input  wire                  eoiStrobe,   // Non-specific EOI write
    output picPkg::irqVec        inServiceBits
);

    picPkg::irqVec isrNext;

    always_comb begin
        isrNext = inServiceBits;
        if (eoiStrobe) begin
            // x & (x - 1) drops the lowest set bit
            // which is the highest priority in service
            isrNext = isrNext & picPkg::irqVec'(isrNext - 1'b1);
        end
        if (setStrobe) begin
            isrNext[setIndex] = 1'b1;   // New level enters service
        end
    end

    always_ff @(posedge clk) begin
        if (resetIRR) begin
            inServiceBits <= '0;
        end else begin
            inServiceBits <= isrNext;
        end
    end

    // Resolver only grants levels above every in-service level
    setOnFreeBit: assert property (
        @(posedge clk) disable iff (resetIRR)
        setStrobe |-> !inServiceBits[setIndex]
    );

endmodule

`default_nettype wire

/* logic/interruptRequestRegister.sv */
// Interrupt request register with edge and level capture, masking and acknowledge clear
`timescale 1ns/1ps
`default_nettype none

module interruptRequestRegister (
    input  wire                  clk,
    input  wire                  resetIRR,
    input  wire picPkg::irqVec   irq,         // Raw request lines
    input  wire picPkg::picConfig cfg,
    input  wire                  clearStrobe, // First acknowledge pulse
    input  wire picPkg::levelIdx clearIndex,  // Level being acknowledged
    output picPkg::irqVec        requestBits,
    output picPkg::irqVec        pendingBits
);

    picPkg::irqVec irqSample;   // Synchronized copy of irq
    picPkg::irqVec irqPrev;     // Sample from the cycle before
    picPkg::irqVec ackHeld;     // Level mode: acknowledged while still high
    picPkg::irqVec clearMask;
    picPkg::irqVec riseBits;
    picPkg::irqVec ackHeldNext;
    picPkg::irqVec requestNext;

    always_comb begin
        clearMask = clearStrobe ? (picPkg::irqVec'(1) << clearIndex) : '0;
        riseBits  = irqSample & ~irqPrev;                 // Low-to-high seen on the samples
        // A flag survives only while its line stays high
        ackHeldNext = (ackHeld | clearMask) & irqSample;
        if (cfg.levelTriggered) begin
            requestNext = irqSample & ~ackHeldNext;       // Follows the line
        end else begin
            requestNext = (requestBits | riseBits) & ~clearMask; // Sticky until acknowledged
        end
    end

    always_ff @(posedge clk) begin
        if (resetIRR) begin
            irqSample   <= '0;
            irqPrev     <= '0;
            ackHeld     <= '0;
            requestBits <= '0;
        end else begin
            irqSample   <= irq;
            irqPrev     <= irqSample;
            ackHeld     <= ackHeldNext;
            requestBits <= requestNext;
        end
    end

    assign pendingBits = requestBits & ~cfg.mask; // Masked lines stay visible in IRR only

    // Acknowledge must name a stored request chosen by the resolver
    clearHitsSetBit: assert property (
        @(posedge clk) disable iff (resetIRR)
        clearStrobe |-> requestBits[clearIndex]
    );

endmodule

`default_nettype wire

/* logic/picControl.sv */
// Command decoder, configuration registers, acknowledge FSM and read/vector outputs
`timescale 1ns/1ps
`default_nettype none
`include "pic_macros.svh"

module picControl (
    input  wire                  clk,
    input  wire                  resetIRR,
    input  wire                  chipSelect,
    input  wire                  writeStrobe,
    input  wire                  readStrobe,
    input  wire                  addr0,
    input  wire picPkg::byteT    writeData,
    input  wire                  intaStrobe,
    input  wire                  intRequest,    // From resolver
    input  wire picPkg::levelIdx winnerIdx,
    input  wire picPkg::irqVec   requestBits,
    input  wire picPkg::irqVec   inServiceBits,
    output picPkg::picConfig     cfg,
    output logic                 intr,
    output logic                 clearStrobe,
    output picPkg::levelIdx      clearIndex,
    output logic                 setStrobe,
    output picPkg::levelIdx      setIndex,
    output logic                 eoiStrobe,
    output picPkg::byteT         readData,
    output picPkg::byteT         vectorOut,
    output logic                 vectorValid
);

    picPkg::ackState ackState;
    picPkg::levelIdx ackIdx;      // Level latched at the first pulse
    logic            icw2Pending; // ICW1 seen, next address-1 write is ICW2
    logic            wrEn;
    logic            rdEn;
    logic            icw1Write;
    logic            ocw3Write;
    logic            ocw2Write;
    logic            ackAccept;   // First pulse taken
    logic            secondPulse;

    always_comb begin
        wrEn      = chipSelect && writeStrobe;
        rdEn      = chipSelect && readStrobe;
        icw1Write = wrEn && !addr0 && writeData[`PIC_ICW1_FLAG];
        ocw3Write = wrEn && !addr0 && !writeData[`PIC_ICW1_FLAG] && writeData[`PIC_OCW3_FLAG];
        ocw2Write = wrEn && !addr0 && !writeData[`PIC_ICW1_FLAG] && !writeData[`PIC_OCW3_FLAG];
        eoiStrobe = ocw2Write && (writeData[7:5] == `PIC_EOI_CODE); // Other OCW2 codes ignored
        // Pulses without a live request are dropped
        ackAccept   = intaStrobe && (ackState == picPkg::ackIdle) && intr && intRequest;
        secondPulse = intaStrobe && (ackState == picPkg::ackFirst);
    end

    // IRR clear and ISR set share the first pulse
    assign clearStrobe = ackAccept;
    assign clearIndex  = winnerIdx;
    assign setStrobe   = ackAccept;
    assign setIndex    = winnerIdx;

    // Configuration and ICW sequencing
    always_ff @(posedge clk) begin
        if (resetIRR) begin
            cfg         <= '0;
            icw2Pending <= 1'b0;
        end else if (icw1Write) begin
            cfg.levelTriggered <= writeData[`PIC_LTIM_BIT];
            cfg.mask           <= '0;
            cfg.readIsrSel     <= 1'b0;  // Back to IRR reads
            cfg.initDone       <= 1'b0;
            icw2Pending        <= 1'b1;
        end else if (wrEn && addr0) begin
            if (icw2Pending) begin
                cfg.vectorBase <= writeData[7:3];  // ICW2
                cfg.initDone   <= 1'b1;
                icw2Pending    <= 1'b0;
            end else begin
                cfg.mask <= writeData;             // OCW1
            end
        end else if (ocw3Write && writeData[`PIC_OCW3_RR_BIT]) begin
            cfg.readIsrSel <= writeData[`PIC_OCW3_RIS_BIT];
        end
    end

    // Acknowledge FSM
    always_ff @(posedge clk) begin
        if (resetIRR) begin
            ackState    <= picPkg::ackIdle;
            intr        <= 1'b0;
            vectorValid <= 1'b0;
        end else begin
            case (ackState)
                picPkg::ackIdle:   if (ackAccept) ackState <= picPkg::ackFirst;
                picPkg::ackFirst:  if (intaStrobe) ackState <= picPkg::ackSecond;
                picPkg::ackSecond: ackState <= picPkg::ackIdle;  // Vector cycle
                default:           ackState <= picPkg::ackIdle;
            endcase
            // Held low through the whole sequence
            intr <= cfg.initDone && intRequest && (ackState == picPkg::ackIdle) && !ackAccept;
            vectorValid <= secondPulse;
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        if (ackAccept) begin
            ackIdx <= winnerIdx;
        end
        if (secondPulse) begin
            vectorOut <= {cfg.vectorBase, ackIdx};
        end
    end

    always_ff @(posedge clk) begin
        if (resetIRR) begin
            readData <= '0;
        end else if (rdEn) begin
            if (addr0) begin
                readData <= cfg.mask;
            end else begin
                readData <= cfg.readIsrSel ? inServiceBits : requestBits; // OCW3 select
            end
        end
    end

    // One vector per acknowledge
    singleVector: assert property (
        @(posedge clk) disable iff (resetIRR)
        vectorValid |=> !vectorValid
    );

endmodule

`default_nettype wire

/* logic/picCore.sv */
// Top level of the reduced 8259-style interrupt controller
`timescale 1ns/1ps
`default_nettype none

module picCore (
    input  wire                clk,
    input  wire                resetIRR,
    input  wire picPkg::irqVec irq,
    input  wire                chipSelect,
    input  wire                writeStrobe,
    input  wire                readStrobe,
    input  wire                addr0,
    input  wire picPkg::byteT  writeData,
    output picPkg::byteT       readData,
    input  wire                intaStrobe,
    output logic               intr,
    output picPkg::byteT       vectorOut,
    output logic               vectorValid
);

    picPkg::picConfig cfg;
    picPkg::irqVec    requestBits;
    picPkg::irqVec    pendingBits;
    picPkg::irqVec    inServiceBits;
    logic             intRequest;
    picPkg::levelIdx  winnerIdx;
    logic             clearStrobe;
    picPkg::levelIdx  clearIndex;
    logic             setStrobe;
    picPkg::levelIdx  setIndex;
    logic             eoiStrobe;

    interruptRequestRegister i_irr (
        .clk, .resetIRR, .irq, .cfg,
        .clearStrobe, .clearIndex,
        .requestBits, .pendingBits
    );

    priorityResolver i_resolver (
        .pendingBits, .inServiceBits,
        .intRequest, .winnerIdx
    );

    inServiceRegister i_isr (
        .clk, .resetIRR,
        .setStrobe, .setIndex, .eoiStrobe,
        .inServiceBits
    );

    picControl i_control (
        .clk, .resetIRR,
        .chipSelect, .writeStrobe, .readStrobe, .addr0, .writeData,
        .intaStrobe, .intRequest, .winnerIdx,
        .requestBits, .inServiceBits,
        .cfg, .intr,
        .clearStrobe, .clearIndex, .setStrobe, .setIndex, .eoiStrobe,
        .readData, .vectorOut, .vectorValid
    );

endmodule

`default_nettype wire

/* logic/picPkg.sv */
// Package with the controller vector types, configuration struct and acknowledge states
`default_nettype none
`include "pic_macros.svh"

package picPkg;

    // One bit per request line
    typedef logic [`PIC_LINES-1:0] irqVec;

    // Index of a request level, 0 is highest priority
    typedef logic [`PIC_IDX_W-1:0] levelIdx;

    // Processor data byte
    typedef logic [`PIC_DATA_W-1:0] byteT;

    // Configuration set by ICW1, ICW2, OCW1 and OCW3
    typedef struct packed {
        logic                   levelTriggered; // LTIM from ICW1
        logic [`PIC_BASE_W-1:0] vectorBase;     // Upper vector bits from ICW2
        irqVec                  mask;           // OCW1 mask, 1 blocks a line
        logic                   readIsrSel;     // OCW3 read select, 1 reads ISR
        logic                   initDone;       // ICW2 seen since last ICW1
    } picConfig;

    // Two-pulse acknowledge sequence
    typedef enum logic [1:0] {
        ackIdle,   // Waiting for first intaStrobe
        ackFirst,  // First pulse taken, waiting for second
        ackSecond  // Vector presented for one cycle
    } ackState;

endpackage

`default_nettype wire

/* logic/priorityResolver.sv */
// Fixed-priority resolver comparing the best pending request against the in-service levels
`timescale 1ns/1ps
`default_nettype none
`include "pic_macros.svh"

module priorityResolver (
    input  wire picPkg::irqVec   pendingBits,   // Unmasked stored requests
    input  wire picPkg::irqVec   inServiceBits,
    output logic                 intRequest,
    output picPkg::levelIdx      winnerIdx      // Lowest-numbered pending line
);

    picPkg::levelIdx isrIdx;  // Highest level currently in service
    logic            pendAny;
    logic            isrAny;

    // Lowest set bit wins, IR0 first
    function automatic picPkg::levelIdx lowestIdx(input picPkg::irqVec bits);
        picPkg::levelIdx idx;
        idx = '0;
        // Walk downward so the smallest index is kept last
        for (int i = `PIC_LINES - 1; i >= 0; i--) begin
            if (bits[i]) begin
                idx = picPkg::levelIdx'(i);
            end
        end
        return idx;
    endfunction

    always_comb begin
        pendAny   = |pendingBits;
        isrAny    = |inServiceBits;
        winnerIdx = lowestIdx(pendingBits);
        isrIdx    = lowestIdx(inServiceBits);
        // Fully nested mode
        // Equal or lower priority waits for EOI
        if (!pendAny) begin
            intRequest = 1'b0;
        end else if (!isrAny) begin
            intRequest = 1'b1;                  // Nothing in service
        end else begin
            intRequest = (winnerIdx < isrIdx);  // Strictly higher priority only
        end
    end

endmodule

`default_nettype wire

/* picCore.f */
+incdir+include
logic/picPkg.sv
logic/interruptRequestRegister.sv
logic/priorityResolver.sv
logic/inServiceRegister.sv
logic/picControl.sv
logic/picCore.sv
tests/picCoreTb.sv

/* tests/picCoreTb.sv */
// Testbench for picCore with file-driven commands, value check task, watchdog and summary
`timescale 1ns/1ps
`default_nettype none
`include "pic_macros.svh"

module picCoreTb;

    localparam int clkPeriodNs   = 100;
    localparam int resetCycles   = 10;
    localparam int captureCycles = 3;   // Sample, store, registered intr

    logic          clk;
    logic          resetIRR;
    picPkg::irqVec irq;
    logic          chipSelect;
    logic          writeStrobe;
    logic          readStrobe;
    logic          addr0;
    picPkg::byteT  writeData;
    picPkg::byteT  readData;
    logic          intaStrobe;
    logic          intr;
    picPkg::byteT  vectorOut;
    logic          vectorValid;

    byte  cmdQ[$];        // Command letters from the data file
    int   argAQ[$];
    int   argBQ[$];
    logic loadDone;       // Releases the watchdog once the length is known
    int   mismatchCount;
    int   timeoutCount;
    int   otherCount;

    picCore i_picCore (
        .clk, .resetIRR, .irq,
        .chipSelect, .writeStrobe, .readStrobe, .addr0, .writeData, .readData,
        .intaStrobe, .intr, .vectorOut, .vectorValid
    );

    always #(clkPeriodNs / 2) clk = ~clk;

    task automatic checkValue(input string name, input picPkg::byteT got,
                              input picPkg::byteT expected);
        if (got !== expected) begin
            $display("Mismatch at time %0t: %s is 0x%02h, expected 0x%02h",
                     $time, name, got, expected);
            mismatchCount++;
        end
    endtask

    // One-cycle write strobe, ends on the next falling edge
    task automatic busWrite(input logic addr, input picPkg::byteT data);
        chipSelect  = 1'b1;
        writeStrobe = 1'b1;
        addr0       = addr;
        writeData   = data;
        @(negedge clk);
        chipSelect  = 1'b0;
        writeStrobe = 1'b0;
    endtask

    task automatic busRead(input logic addr, input picPkg::byteT expected);
        chipSelect = 1'b1;
        readStrobe = 1'b1;
        addr0      = addr;
        @(negedge clk);
        chipSelect = 1'b0;
        readStrobe = 1'b0;
        checkValue("readData", readData, expected);   // Registered on the edge in between
    endtask

    task automatic driveIrq(input picPkg::irqVec value);
        irq = value;
        repeat (captureCycles) @(negedge clk);
    endtask

    // Two intaStrobe pulses with a gap, then the vector check
    task automatic ackSequence(input picPkg::byteT expVector);
        int waited;
        waited = 0;
        while (!intr && waited < `PIC_WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!intr) begin
            $display("Timeout at time %0t: intr did not rise within %0d cycles",
                     $time, `PIC_WAIT_LIMIT);
            timeoutCount++;
        end else begin
            intaStrobe = 1'b1;
            @(negedge clk);
            intaStrobe = 1'b0;
            checkValue("intr", picPkg::byteT'(intr), 8'h00); // Low after the first pulse
            @(negedge clk);
            intaStrobe = 1'b1;
            @(negedge clk);
            intaStrobe = 1'b0;
            waited = 0;
            while (!vectorValid && waited < `PIC_WAIT_LIMIT) begin
                @(negedge clk);
                waited++;
            end
            if (!vectorValid) begin
                $display("Timeout at time %0t: vectorValid did not rise within %0d cycles",
                         $time, `PIC_WAIT_LIMIT);
                timeoutCount++;
            end else begin
                checkValue("vectorOut", vectorOut, expVector);
                @(negedge clk);
                checkValue("vectorValid", picPkg::byteT'(vectorValid), 8'h00); // One cycle only
            end
        end
    endtask

    task automatic expectQuiet();
        logic sawIntr;
        sawIntr = intr;
        repeat (`PIC_QUIET_CYCLES) begin
            @(negedge clk);
            sawIntr = sawIntr | intr;
        end
        checkValue("intr", picPkg::byteT'(sawIntr), 8'h00);
    endtask

    task automatic runCommand(input byte cmd, input int argA, input int argB);
        case (cmd)
            "W": busWrite(argA[0], argB[7:0]);
            "R": busRead(argA[0], argB[7:0]);
            "I": driveIrq(argA[7:0]);
            "A": ackSequence(argA[7:0]);
            "N": expectQuiet();
            "E": busWrite(1'b0, {`PIC_EOI_CODE, 5'b00000}); // OCW2 at address 0
            default: begin
                $display("Unknown command letter %c in the test data", cmd);
                otherCount++;
            end
        endcase
    endtask

    initial begin : mainFlow
        int    fd;
        int    status;
        int    seedDummy;
        string lineText;
        byte   cmdChar;
        int    argA;
        int    argB;
        clk           = 1'b0;
        resetIRR      = 1'b1;
        irq           = '0;
        chipSelect    = 1'b0;
        writeStrobe   = 1'b0;
        readStrobe    = 1'b0;
        addr0         = 1'b0;
        writeData     = '0;
        intaStrobe    = 1'b0;
        loadDone      = 1'b0;
        mismatchCount = 0;
        timeoutCount  = 0;
        otherCount    = 0;
        seedDummy     = $urandom(32'h87680eb2);
        fd = $fopen("tests/picCore_testdata.txt", "r");
        if (fd == 0) begin
            $display("Error: the test data file tests/picCore_testdata.txt cannot be opened");
            otherCount++;
        end else begin
            while (!$feof(fd)) begin
                lineText = "";
                status   = $fgets(lineText, fd);
                // Blank and comment lines carry no command
                if (status > 0 && lineText.len() > 0 && lineText[0] != "#" &&
                    lineText[0] != "\n") begin
                    argA   = 0;
                    argB   = 0;
                    status = $sscanf(lineText, "%c %h %h", cmdChar, argA, argB);
                    cmdQ.push_back(cmdChar);
                    argAQ.push_back(argA);
                    argBQ.push_back(argB);
                end
            end
            $fclose(fd);
        end
        loadDone = 1'b1;
        repeat (resetCycles) @(negedge clk);
        resetIRR = 1'b0;
        foreach (cmdQ[i]) begin
            runCommand(cmdQ[i], argAQ[i], argBQ[i]);
            repeat ($urandom % 4) @(negedge clk);   // Idle gap of 0 to 3 cycles
        end
        $display("Summary: %0d mismatches, %0d timeouts, %0d other errors",
                 mismatchCount, timeoutCount, otherCount);
        if (mismatchCount + timeoutCount + otherCount == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // Budget grows with the number of command lines, one spare command slot
    initial begin : watchdog
        longint limitNs;
        wait (loadDone);
        limitNs = longint'((cmdQ.size() + 1) * `PIC_CYCLES_PER_CMD + resetCycles) * clkPeriodNs;
        #(limitNs);
        $display("Watchdog expired at time %0t: the command sequence did not finish", $time);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

/* tests/picCore_testdata.txt */
# Columns: command letter, then hex arguments. W addr data, R addr expected, I irq, A vector
# N expects intr low for 8 cycles, E writes a non-specific EOI
# Edge mode, base 0x40, mask read-back
W 0 10
W 1 40
W 1 80
R 1 80
I 08
A 43
N
E
N
I 00
# Nesting with IR5 in service
I 20
A 45
I 64
A 42
W 0 0A
R 0 40
W 0 0B
R 0 24
N
E
R 0 20
N
E
A 46
E
R 0 00
I 00
# Level mode, base 0x48, IR7 masked
W 0 18
W 1 48
W 1 80
I 82
A 49
E
N
R 0 80
I 80
I 82
A 49
E
I 00
R 1 80
N
